// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module tb_dcache -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_dcache)"; echo "$$out"; \
		echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// File: dcache_array.sv
// Frame storage for all sets with one indexed read port and one set-wide write port
`timescale 1ns/1ps

module dcache_array (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [dcache_pkg::INDEX_W-1:0] rd_index,
    input  logic                           wr_en,
    input  logic [dcache_pkg::INDEX_W-1:0] wr_index,
    input  dcache_pkg::set_t               wr_set,
    output dcache_pkg::set_t               rd_set
);
    import dcache_pkg::*;

    set_t [SETS-1:0] sets;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sets <= '0;   // All frames invalid and clean
        end else if (wr_en) begin
            sets[wr_index] <= wr_set;
        end
    end

    // Combinational read
    assign rd_set = sets[rd_index];

endmodule

// File: dcache_ctrl.sv
// Cache controller FSM for hits, victim write-back, block fill and halt flush
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                           CLK,
    input  logic                           nRST,
    input  dcache_pkg::dcache_req_t        req,
    input  logic                           halt,
    input  logic [dcache_pkg::TAG_W-1:0]   tag,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic                           word_sel,
    input  logic                           match,
    input  logic                           match_way,
    input  dcache_pkg::set_t               rd_set,
    input  logic                           dwait,
    input  dcache_pkg::word_t              mem_load,
    output logic [dcache_pkg::INDEX_W-1:0] rd_index,
    output logic                           wr_en,
    output logic [dcache_pkg::INDEX_W-1:0] wr_index,
    output dcache_pkg::set_t               wr_set,
    output dcache_pkg::mem_req_t           mem,
    output logic                           hit,
    output dcache_pkg::word_t              load,
    output logic                           flushed
);
    import dcache_pkg::*;

    ctrl_state_t          state, nxt_state;
    logic [FLUSH_W-1:0]   flush_cnt, nxt_flush_cnt;
    logic [INDEX_W-1:0]   flush_index;
    logic                 flush_way;
    logic                 flushing;
    logic                 victim_way;
    frame_t               victim;
    frame_t               flush_frame;

    function automatic frame_t get_frame(set_t s, logic way);
        return way ? s.right : s.left;
    endfunction

    function automatic set_t put_frame(set_t s, logic way, frame_t f);
        set_t r;
        r = s;
        if (way) begin
            r.right = f;
        end else begin
            r.left = f;
        end
        return r;
    endfunction

    function automatic word_t block_addr(logic [TAG_W-1:0] t, logic [INDEX_W-1:0] i, logic w);
        return {t, i, w, 2'b00};
    endfunction

    assign flush_index = flush_cnt[INDEX_W-1:0];
    assign flush_way   = flush_cnt[INDEX_W];
    assign flushing    = (state == FLUSH_CHECK) || (state == FLUSH_WB1) || (state == FLUSH_WB2);

    // Flush walk reads the counter's set
    assign rd_index = flushing ? flush_index : index;
    assign wr_index = rd_index;

    assign victim_way  = ~rd_set.mru;
    assign victim      = get_frame(rd_set, victim_way);
    assign flush_frame = get_frame(rd_set, flush_way);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            state     <= nxt_state;
            flush_cnt <= nxt_flush_cnt;
        end
    end

    always_comb begin
        nxt_state     = state;
        nxt_flush_cnt = flush_cnt;
        case (state)
            IDLE: begin
                if (halt) begin
                    nxt_state = FLUSH_CHECK;
                end else if ((req.ren || req.wen) && !match) begin
                    nxt_state = CHECK;
                end
            end
            CHECK: begin
                nxt_state = (victim.valid && victim.dirty) ? WB1 : FILL1;
            end
            WB1: begin
                if (!dwait) begin
                    nxt_state = WB2;
                end
            end
            WB2: begin
                if (!dwait) begin
                    nxt_state = FILL1;
                end
            end
            FILL1: begin
                if (!dwait) begin
                    nxt_state = FILL2;
                end
            end
            FILL2: begin
                if (!dwait) begin
                    nxt_state = IDLE;   // Request hits next cycle
                end
            end
            FLUSH_CHECK: begin
                if (flush_cnt[FLUSH_W-1]) begin
                    nxt_state = DONE;
                end else if (flush_frame.valid && flush_frame.dirty) begin
                    nxt_state = FLUSH_WB1;
                end else begin
                    nxt_flush_cnt = flush_cnt + 1'b1;
                end
            end
            FLUSH_WB1: begin
                if (!dwait) begin
                    nxt_state = FLUSH_WB2;
                end
            end
            FLUSH_WB2: begin
                if (!dwait) begin
                    nxt_state     = FLUSH_CHECK;
                    nxt_flush_cnt = flush_cnt + 1'b1;
                end
            end
            DONE: begin
                nxt_state = DONE;   // Held until reset
            end
            default: begin
                nxt_state = IDLE;
            end
        endcase
    end

    always_comb begin
        frame_t f;
        f       = '0;
        wr_en   = 1'b0;
        wr_set  = rd_set;
        mem     = '0;
        hit     = 1'b0;
        load    = '0;
        flushed = 1'b0;
        case (state)
            IDLE: begin
                if (match) begin
                    hit = 1'b1;
                    f   = get_frame(rd_set, match_way);
                    if (req.wen) begin
                        f.data[word_sel] = req.store;
                        f.dirty          = 1'b1;
                    end else begin
                        load = f.data[word_sel];
                    end
                    wr_set     = put_frame(rd_set, match_way, f);
                    wr_set.mru = match_way;
                    wr_en      = 1'b1;
                end
            end
            WB1: begin
                mem.wen   = 1'b1;
                mem.addr  = block_addr(victim.tag, index, 1'b0);
                mem.store = victim.data[0];
            end
            WB2: begin
                mem.wen   = 1'b1;
                mem.addr  = block_addr(victim.tag, index, 1'b1);
                mem.store = victim.data[1];
                if (!dwait) begin
                    f       = victim;
                    f.valid = 1'b0;
                    wr_set  = put_frame(rd_set, victim_way, f);
                    wr_en   = 1'b1;
                end
            end
            FILL1: begin
                mem.ren  = 1'b1;
                mem.addr = block_addr(tag, index, 1'b0);
                if (!dwait) begin
                    f         = victim;
                    f.valid   = 1'b0;   // Stale tag must not match mid-fill
                    f.data[0] = mem_load;
                    wr_set    = put_frame(rd_set, victim_way, f);
                    wr_en     = 1'b1;
                end
            end
            FILL2: begin
                mem.ren  = 1'b1;
                mem.addr = block_addr(tag, index, 1'b1);
                if (!dwait) begin
                    f         = victim;
                    f.data[1] = mem_load;
                    f.tag     = tag;
                    f.valid   = 1'b1;
                    f.dirty   = 1'b0;
                    wr_set    = put_frame(rd_set, victim_way, f);
                    wr_en     = 1'b1;
                end
            end
            FLUSH_WB1: begin
                mem.wen   = 1'b1;
                mem.addr  = block_addr(flush_frame.tag, flush_index, 1'b0);
                mem.store = flush_frame.data[0];
            end
            FLUSH_WB2: begin
                mem.wen   = 1'b1;
                mem.addr  = block_addr(flush_frame.tag, flush_index, 1'b1);
                mem.store = flush_frame.data[1];
            end
            DONE: begin
                flushed = 1'b1;
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

endmodule

// File: dcache_lookup.sv
// Address split and two-way tag compare for the indexed set
`timescale 1ns/1ps

module dcache_lookup (
    input  dcache_pkg::dcache_req_t        req,
    input  dcache_pkg::set_t               set_q,
    output logic [dcache_pkg::TAG_W-1:0]   tag,
    output logic [dcache_pkg::INDEX_W-1:0] index,
    output logic                           word_sel,
    output logic                           match,
    output logic                           match_way
);
    import dcache_pkg::*;

    logic active;
    logic left_hit;
    logic right_hit;

    // Address fields
    assign tag      = req.addr[WORD_W-1 -: TAG_W];
    assign index    = req.addr[OFFSET_W +: INDEX_W];
    assign word_sel = req.addr[OFFSET_W-1];

    assign active = req.ren || req.wen;

    always_comb begin
        left_hit  = set_q.left.valid && (set_q.left.tag == tag);
        right_hit = set_q.right.valid && (set_q.right.tag == tag);
    end

    always_comb begin
        match     = 1'b0;
        match_way = 1'b0;
        if (active) begin
            if (left_hit) begin
                match     = 1'b1;
                match_way = 1'b0;   // Left wins a double match
            end else if (right_hit) begin
                match     = 1'b1;
                match_way = 1'b1;
            end
        end
    end

endmodule

// File: dcache_pkg.sv
// Cache geometry constants, word/frame/set/request structs and controller states
package dcache_pkg;

    localparam int WORD_W   = 32;
    localparam int INDEX_W  = 3;
    localparam int SETS     = 8;
    localparam int OFFSET_W = 3;   // Bit 2 picks the word
    localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W;
    localparam int FLUSH_W  = 5;   // End bit, way bit, set bits

    typedef logic [WORD_W-1:0] word_t;

    // One way of a set
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
        word_t [1:0]      data;
    } frame_t;

    typedef struct packed {
        frame_t left;
        frame_t right;
        logic   mru;   // Way last hit, 1 is right
    } set_t;

    // Processor side request
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dcache_req_t;

    // Memory side request
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } mem_req_t;

    typedef enum logic [3:0] {
        IDLE,
        CHECK,
        WB1,
        WB2,
        FILL1,
        FILL2,
        FLUSH_CHECK,
        FLUSH_WB1,
        FLUSH_WB2,
        DONE
    } ctrl_state_t;

endpackage

// File: dcache_top.sv
// Data cache top level joining lookup, controller and frame array
`timescale 1ns/1ps

module dcache_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  dcache_pkg::dcache_req_t req,
    input  logic                    halt,
    input  logic                    dwait,
    input  dcache_pkg::word_t       mem_load,
    output logic                    hit,
    output dcache_pkg::word_t       load,
    output logic                    flushed,
    output dcache_pkg::mem_req_t    mem
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic               word_sel;
    logic               match;
    logic               match_way;
    logic [INDEX_W-1:0] rd_index;
    logic [INDEX_W-1:0] wr_index;
    logic               wr_en;
    set_t               rd_set;
    set_t               wr_set;

    dcache_lookup lookup (
        .req       (req),
        .set_q     (rd_set),
        .tag       (tag),
        .index     (index),
        .word_sel  (word_sel),
        .match     (match),
        .match_way (match_way)
    );

    dcache_array array (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_set   (wr_set),
        .rd_set   (rd_set)
    );

    dcache_ctrl ctrl (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (req),
        .halt      (halt),
        .tag       (tag),
        .index     (index),
        .word_sel  (word_sel),
        .match     (match),
        .match_way (match_way),
        .rd_set    (rd_set),
        .dwait     (dwait),
        .mem_load  (mem_load),
        .rd_index  (rd_index),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_set    (wr_set),
        .mem       (mem),
        .hit       (hit),
        .load      (load),
        .flushed   (flushed)
    );

endmodule

// File: filelist.f
dcache_pkg.sv
dcache_lookup.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: tb_dcache.sv
// Data cache testbench with clock, reset, LCG stalls, stimulus table, checks and summary
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int N_ENTRIES = 14;
    localparam int DEPTH     = 1024;
    localparam int TIMEOUT   = (N_ENTRIES + 16) * 40 + 16;   // Cycles, flush included
    localparam logic [1:0] OP_RD   = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_HALT = 2'd2;

    logic        CLK = 1'b0;
    logic        nRST;
    dcache_req_t req;
    logic        halt;
    logic        stall;
    logic        dwait;
    word_t       mem_load;
    logic        hit;
    word_t       load;
    logic        flushed;
    mem_req_t    mem;

    string       names [N_ENTRIES];
    logic [1:0]  ops   [N_ENTRIES];
    word_t       addrs [N_ENTRIES];
    word_t       datas [N_ENTRIES];
    word_t       exps  [N_ENTRIES];
    word_t       ref_mem [DEPTH];   // Expected memory image
    logic [31:0] seed;
    int          n_entries;
    int          tests;
    int          errors;
    int          cycles = 0;

    dcache_top UUT (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (req),
        .halt     (halt),
        .dwait    (dwait),
        .mem_load (mem_load),
        .hit      (hit),
        .load     (load),
        .flushed  (flushed),
        .mem      (mem)
    );

    tb_mem_model mem_model (
        .CLK      (CLK),
        .mem      (mem),
        .stall    (stall),
        .dwait    (dwait),
        .mem_load (mem_load)
    );

    always #2 CLK = ~CLK;

    function automatic word_t rule_value(word_t addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Expected load follows the memory image at the time of the entry
    task automatic add_entry(string name, logic [1:0] op, word_t addr, word_t data);
        names[n_entries] = name;
        ops[n_entries]   = op;
        addrs[n_entries] = addr;
        datas[n_entries] = data;
        exps[n_entries]  = '0;
        if (op == OP_RD) begin
            exps[n_entries] = ref_mem[addr[11:2]];
        end else if (op == OP_WR) begin
            ref_mem[addr[11:2]] = data;
        end
        n_entries++;
    endtask

    task automatic build_table();
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = rule_value(word_t'(i << 2));
        end
        add_entry("rd_cold_w0", OP_RD,   32'h0000_0040, 32'h0);
        add_entry("rd_hit_w1",  OP_RD,   32'h0000_0044, 32'h0);
        add_entry("wr_hit_w1",  OP_WR,   32'h0000_0044, 32'h1111_2222);
        add_entry("rd_back_w1", OP_RD,   32'h0000_0044, 32'h0);
        add_entry("rd_keep_w0", OP_RD,   32'h0000_0040, 32'h0);
        add_entry("wr_set2_a",  OP_WR,   32'h0000_0010, 32'hAAAA_0001);   // Three tags, set 2
        add_entry("wr_set2_b",  OP_WR,   32'h0000_0050, 32'hBBBB_0002);
        add_entry("wr_set2_c",  OP_WR,   32'h0000_0094, 32'hCCCC_0003);
        add_entry("rd_evict_a", OP_RD,   32'h0000_0010, 32'h0);
        add_entry("rd_other_a", OP_RD,   32'h0000_0014, 32'h0);
        add_entry("rd_evict_b", OP_RD,   32'h0000_0050, 32'h0);
        add_entry("rd_evict_c", OP_RD,   32'h0000_0094, 32'h0);
        add_entry("wr_set0_d",  OP_WR,   32'h0000_00C0, 32'hDDDD_0004);
        add_entry("halt_flush", OP_HALT, 32'h0,         32'h0);
    endtask

    task automatic report(string name, word_t exp, word_t got);
        tests++;
        assert (got == exp) begin
            $display("ok    %s  value %h", name, got);
        end else begin
            $display("error: %s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_idle_quiet();
        logic bad;
        bad = 1'b0;
        repeat (8) begin
            @(negedge CLK);
            if (hit || flushed || mem.ren || mem.wen) begin
                bad = 1'b1;
            end
        end
        tests++;
        assert (!bad) begin
            $display("ok    idle_quiet");
        end else begin
            $display("idle_quiet: an output rose with no request pending");
            errors++;
        end
    endtask

    task automatic check_memory(string name);
        int bad;
        bad = 0;
        for (int a = 0; a < DEPTH; a++) begin
            assert (mem_model.store[a] == ref_mem[a]) else begin
                $display("error: %s word %h expected %h actual %h",
                         name, a * 4, ref_mem[a], mem_model.store[a]);
                bad++;
            end
        end
        tests++;
        if (bad == 0) begin
            $display("ok    %s  memory image matches", name);
        end else begin
            errors++;
        end
    endtask

    task automatic apply_entry(int i);
        word_t got;
        got = '0;
        if (ops[i] == OP_HALT) begin
            halt = 1'b1;
            @(negedge CLK);
            while (!flushed) @(negedge CLK);
            check_memory(names[i]);
        end else begin
            req.ren   = (ops[i] == OP_RD);
            req.wen   = (ops[i] == OP_WR);
            req.addr  = addrs[i];
            req.store = datas[i];
            @(negedge CLK);
            while (!hit) @(negedge CLK);   // Miss latency varies
            got = load;
            @(posedge CLK);
            #1;
            req = '0;
            report(names[i], exps[i], got);
        end
    endtask

    // Random stalls on the memory side
    always begin
        @(posedge CLK);
        #1;
        seed  = lcg_next(seed);
        stall = nRST && (({16'd0, seed[31:16]} % 32'd3) == 32'd0);
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: no hit or flushed after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        nRST      = 1'b0;
        req       = '0;
        halt      = 1'b0;
        stall     = 1'b0;
        seed      = 32'd71563;
        n_entries = 0;
        tests     = 0;
        errors    = 0;
        build_table();
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        check_idle_quiet();
        @(posedge CLK);
        #1;
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb_mem_model.sv
// Testbench memory model with word-indexed store, seeded contents and stall-driven wait
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                 CLK,
    input  dcache_pkg::mem_req_t mem,
    input  logic                 stall,
    output logic                 dwait,
    output dcache_pkg::word_t    mem_load
);
    import dcache_pkg::*;

    localparam int DEPTH = 1024;   // 4 KB of words

    word_t      store [DEPTH];
    logic [9:0] waddr;

    function automatic word_t seed_word(int idx);
        return word_t'(idx << 2) ^ 32'hA5A5_0000;
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            store[i] = seed_word(i);   // Address-based fill
        end
    end

    assign waddr    = mem.addr[11:2];
    assign dwait    = stall;
    assign mem_load = mem.ren ? store[waddr] : '0;

    always @(posedge CLK) begin
        if (mem.wen && !dwait) begin
            store[waddr] <= mem.store;   // Transfer completes on low dwait
        end
    end

endmodule
